// File: list.f
trn_rx_pkg.sv
rx_beat_decode.sv
rx_prev_buffer.sv
rx_output_stage.sv
trn_axi_rx_bridge.sv
trn_axi_rx_sva.sv
rx_scoreboard.sv
tb_trn_axi_rx.sv

// File: tb_trn_axi_rx.sv
`timescale 1ns/10ps
`default_nettype none

module tb_trn_axi_rx
  import trn_rx_pkg::*;
();

  localparam int BEAT_W = DATA_W + KEEP_W + 1 + TUSER_W;  // {data, keep, last, tuser}
  localparam int N_FULL = 16;
  localparam int N_POS  = 8;
  localparam int N_RAND = 40;
  localparam int STIM_CYCLES = (N_FULL + N_POS + N_RAND) * 12 + 20;  // Six beats plus gaps
  localparam int LIMIT = 4 * STIM_CYCLES + 100;

  logic              user_clk;
  logic              user_rst;
  rx_data_t          trn_rd;
  logic              trn_rsof;
  logic              trn_reof;
  logic              trn_rsrc_rdy;
  logic              trn_rdst_rdy;
  logic              trn_rrem;
  logic              trn_rerrfwd;
  logic              trn_recrc_err;
  bar_hit_t          trn_rbar_hit;
  rx_data_t          m_axis_rx_tdata;
  logic              m_axis_rx_tvalid;
  logic              m_axis_rx_tready;
  rx_keep_t          m_axis_rx_tkeep;
  logic              m_axis_rx_tlast;
  rx_tuser_t         m_axis_rx_tuser;
  logic [BEAT_W-1:0] exp_beat;   // Reference for the slot now on the TRN bus
  logic              full_rate;
  logic              rand_rdy;   // Random tready when set
  logic              took = 1'b0;  // Slot accepted at the last rising edge
  logic [31:0]       lfsr;
  int                tb_errors;
  int                sb_errors;
  int                checked;
  int                pending;
  int                cycles;
  int                total;

  trn_axi_rx_bridge uut (.*);

  rx_scoreboard u_sb (
    .user_clk(user_clk), .user_rst(user_rst), .full_rate(full_rate), .exp_beat(exp_beat),
    .trn_rsrc_rdy(trn_rsrc_rdy), .trn_rdst_rdy(trn_rdst_rdy),
    .m_axis_rx_tdata(m_axis_rx_tdata), .m_axis_rx_tvalid(m_axis_rx_tvalid),
    .m_axis_rx_tready(m_axis_rx_tready), .m_axis_rx_tkeep(m_axis_rx_tkeep),
    .m_axis_rx_tlast(m_axis_rx_tlast), .m_axis_rx_tuser(m_axis_rx_tuser),
    .errors(sb_errors), .checked(checked), .pending(pending)
  );

  initial begin
    user_clk = 1'b0;
    forever #4 user_clk = ~user_clk;  // 125 MHz
  end

  always @(posedge user_clk) took <= trn_rdst_rdy;

  // ----------------------------------------------------------
  // Reference model and random source
  // ----------------------------------------------------------
  function automatic logic [BEAT_W-1:0] ref_beat(input rx_data_t rd, input logic sof,
      input logic eof, input logic rrem, input bar_hit_t bar, input logic errfwd,
      input logic ecrc);
    logic [21:0] user;
    // is_eof, two zero bits, is_sof, zero bit, BAR hit, error flags
    user = {eof, 1'b0, rrem, 2'b11, 2'b00, sof, 4'b0000, 1'b0, bar, errfwd, ecrc};
    return {rd[31:0], rd[63:32], (rrem ? 8'hFF : 8'h0F), eof, user};
  endfunction

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[62:0], lfsr[0]};
    end
  endtask

  task automatic step_ready();
    logic [63:0] b;
    if (rand_rdy) begin
      take_bits(2, b);
      m_axis_rx_tready = b[0] | b[1];  // Ready about three cycles in four
    end else begin
      m_axis_rx_tready = 1'b1;
    end
  endtask

  // ----------------------------------------------------------
  // TRN driver, a slot stays on the bus until the core sees it taken
  // ----------------------------------------------------------
  task automatic put_slot(input logic vld, input logic sof, input logic eof,
                          input logic rrem);
    logic [63:0] d;
    logic [63:0] b;
    take_bits(64, d);
    take_bits(9, b);
    trn_rd        = d;
    trn_rbar_hit  = b[8:2];
    trn_rerrfwd   = b[1];
    trn_recrc_err = b[0];
    trn_rsof      = sof;
    trn_reof      = eof;
    trn_rrem      = rrem;
    trn_rsrc_rdy  = vld;
    exp_beat      = ref_beat(d, sof, eof, rrem, b[8:2], b[1], b[0]);
    step_ready();
    @(negedge user_clk);
    while (!took) begin
      step_ready();
      @(negedge user_clk);
    end
  endtask

  task automatic send_packet(input int len, input logic rrem_last);
    logic [63:0] g;
    for (int i = 0; i < len; i++) begin
      take_bits(2, g);
      if (g[1:0] == 2'b11) put_slot(1'b0, 1'b0, 1'b0, 1'b1);  // Idle gap
      put_slot(1'b1, i == 0, i == len - 1, (i == len - 1) ? rrem_last : 1'b1);
    end
  endtask

  task automatic send_random_packet();
    logic [63:0] r;
    int len;
    take_bits(3, r);
    len = 1 + int'(r[2:0]) % 6;
    take_bits(1, r);
    send_packet(len, r[0]);
  endtask

  task automatic drain();
    rand_rdy         = 1'b0;
    trn_rsrc_rdy     = 1'b0;
    m_axis_rx_tready = 1'b1;
    while (pending != 0 || m_axis_rx_tvalid) @(negedge user_clk);
    repeat (4) @(negedge user_clk);  // Catch any duplicate beat
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s finished, %0d beats checked, %0d errors so far", num, name,
             checked, tb_errors + sb_errors + uut.u_sva.fails);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    user_rst         = 1'b1;
    trn_rd           = '0;
    trn_rsof         = 1'b0;
    trn_reof         = 1'b0;
    trn_rsrc_rdy     = 1'b0;
    trn_rrem         = 1'b0;
    trn_rerrfwd      = 1'b0;
    trn_recrc_err    = 1'b0;
    trn_rbar_hit     = '0;
    m_axis_rx_tready = 1'b1;
    exp_beat         = '0;
    full_rate        = 1'b0;
    rand_rdy         = 1'b0;
    lfsr             = 32'h9f06a120;
    tb_errors        = 0;
    repeat (2) @(posedge user_clk);
    @(negedge user_clk);
    user_rst = 1'b0;
    if (m_axis_rx_tvalid !== 1'b0 || m_axis_rx_tkeep !== 8'hFF ||
        m_axis_rx_tuser !== '0 || trn_rdst_rdy !== 1'b0) begin
      tb_errors++;
      $display("ERR %0t: reset state tvalid %b tkeep %h tuser %h dst_rdy %b", $time,
               m_axis_rx_tvalid, m_axis_rx_tkeep, m_axis_rx_tuser, trn_rdst_rdy);
    end
    @(negedge user_clk);
    if (trn_rdst_rdy !== 1'b1) begin
      tb_errors++;
      $display("ERR %0t: trn_rdst_rdy still low after reset release", $time);
    end
    report_test(1, "reset state");

    full_rate = 1'b1;
    for (int i = 0; i < N_FULL; i++) send_random_packet();
    drain();
    report_test(2, "full-rate transfer");

    for (int i = 0; i < N_POS; i++) send_packet((i < 4) ? 1 : i - 2, i[0]);  // Both rrem values
    drain();
    full_rate = 1'b0;
    report_test(3, "position flags");

    rand_rdy = 1'b1;
    for (int i = 0; i < N_RAND; i++) send_random_packet();
    drain();
    report_test(4, "random back-pressure");

    total = tb_errors + sb_errors + uut.u_sva.fails;
    $display("Done: %0d beats checked, %0d errors, %0d assertion failures", checked,
             tb_errors + sb_errors, uut.u_sva.fails);
    if (total == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < LIMIT) begin
      @(posedge user_clk);
      cycles++;
    end
    $display("Timeout after %0d clock cycles, the stimulus never completed", LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: rx_scoreboard.sv
`timescale 1ns/10ps
`default_nettype none

// Records every accepted TRN beat and checks it against the AXI transfers
module rx_scoreboard
  import trn_rx_pkg::*;
(
  input  wire                     user_clk,
  input  wire                     user_rst,
  input  wire                     full_rate,     // tready held high, latency must be one
  input  wire [DATA_W+KEEP_W+TUSER_W:0] exp_beat,  // {data, keep, last, tuser}
  input  wire                     trn_rsrc_rdy,
  input  wire                     trn_rdst_rdy,
  input  wire rx_data_t           m_axis_rx_tdata,
  input  wire                     m_axis_rx_tvalid,
  input  wire                     m_axis_rx_tready,
  input  wire rx_keep_t           m_axis_rx_tkeep,
  input  wire                     m_axis_rx_tlast,
  input  wire rx_tuser_t          m_axis_rx_tuser,
  output int                      errors,
  output int                      checked,       // AXI beats compared
  output int                      pending        // Accepted, not yet seen on AXI
);

  logic [DATA_W+KEEP_W+TUSER_W:0] exp_q[$];  // Expected beats in order
  int                             cyc_q[$];  // Edge each beat was accepted on
  logic [DATA_W+KEEP_W+TUSER_W:0] got;
  logic [DATA_W+KEEP_W+TUSER_W:0] want;
  int                             cycle;
  int                             push_cyc;
  logic                           last_tvalid;
  logic                           last_tready;
  logic                           last_rst = 1'b1;

  initial begin
    errors  = 0;
    checked = 0;
    pending = 0;
    cycle   = 0;
  end

  always @(posedge user_clk) begin
    cycle++;
    if (user_rst) begin
      exp_q.delete();
      cyc_q.delete();
    end else begin
      // ----------------------------------------------------------
      // AXI transfer, compare with oldest accepted beat
      // ----------------------------------------------------------
      if (m_axis_rx_tvalid && m_axis_rx_tready) begin
        got = {m_axis_rx_tdata, m_axis_rx_tkeep, m_axis_rx_tlast, m_axis_rx_tuser};
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERR %0t: AXI beat %h with no accepted TRN beat", $time, got);
        end else begin
          want     = exp_q.pop_front();
          push_cyc = cyc_q.pop_front();
          checked++;
          if (got !== want) begin
            errors++;
            $display("ERR %0t: beat %0d got %h expected %h", $time, checked, got, want);
          end
          if (full_rate && cycle - push_cyc != 1) begin
            errors++;
            $display("ERR %0t: beat %0d latency %0d cycles, expected 1", $time, checked,
                     cycle - push_cyc);
          end
        end
      end
      // TRN acceptance
      if (trn_rsrc_rdy && trn_rdst_rdy) begin
        exp_q.push_back(exp_beat);
        cyc_q.push_back(cycle);
      end
      // Destination ready mirrors tready of the last edge while a beat was offered
      if (!last_rst && last_tvalid && trn_rdst_rdy !== last_tready) begin
        errors++;
        $display("ERR %0t: trn_rdst_rdy %b, tready at last edge was %b", $time,
                 trn_rdst_rdy, last_tready);
      end
    end
    last_tvalid <= m_axis_rx_tvalid;
    last_tready <= m_axis_rx_tready;
    last_rst    <= user_rst;
    pending = exp_q.size();
  end

endmodule

`default_nettype wire

// File: trn_axi_rx_sva.sv
`timescale 1ns/10ps
`default_nettype none

// Protocol rules on the bridge outputs, bound into trn_axi_rx_bridge
module trn_axi_rx_sva
  import trn_rx_pkg::*;
(
  input wire            user_clk,
  input wire            user_rst,
  input wire            trn_rdst_rdy,
  input wire rx_data_t  m_axis_rx_tdata,
  input wire            m_axis_rx_tvalid,
  input wire            m_axis_rx_tready,
  input wire rx_keep_t  m_axis_rx_tkeep,
  input wire            m_axis_rx_tlast,
  input wire rx_tuser_t m_axis_rx_tuser
);

  int fails = 0;  // Count of failed assertions

  // ----------------------------------------------------------
  // AXI side
  // ----------------------------------------------------------
  // A refused beat stays on the bus untouched
  hold_stable: assert property (@(posedge user_clk) disable iff (user_rst)
      m_axis_rx_tvalid && !m_axis_rx_tready |=>
        $stable({m_axis_rx_tdata, m_axis_rx_tvalid, m_axis_rx_tkeep,
                 m_axis_rx_tlast, m_axis_rx_tuser}))
    else begin
      fails++;
      $error("AXI outputs changed while the beat was held");
    end

  reset_idle: assert property (@(posedge user_clk) user_rst |=> !m_axis_rx_tvalid)
    else begin
      fails++;
      $error("tvalid high on the cycle after reset");
    end

  // ----------------------------------------------------------
  // TRN side
  // ----------------------------------------------------------
  // Nothing offered, so the core must be let through
  idle_open: assert property (@(posedge user_clk) disable iff (user_rst)
      !m_axis_rx_tvalid |=> trn_rdst_rdy)
    else begin
      fails++;
      $error("trn_rdst_rdy low one edge after tvalid was low");
    end

endmodule

bind trn_axi_rx_bridge trn_axi_rx_sva u_sva (.*);

`default_nettype wire

// File: trn_axi_rx_bridge.sv
`timescale 1ns/10ps
`default_nettype none

// TRN receive to AXI4-Stream master bridge, 64-bit
module trn_axi_rx_bridge
  import trn_rx_pkg::*;
(
  input  wire             user_clk,
  input  wire             user_rst,          // Synchronous, active high

  // TRN receive from the core
  input  wire rx_data_t   trn_rd,
  input  wire             trn_rsof,
  input  wire             trn_reof,
  input  wire             trn_rsrc_rdy,
  output logic            trn_rdst_rdy,      // Registered back-pressure
  input  wire             trn_rrem,
  input  wire             trn_rerrfwd,
  input  wire bar_hit_t   trn_rbar_hit,
  input  wire             trn_recrc_err,

  // AXI4-Stream master to the user
  output rx_data_t        m_axis_rx_tdata,
  output logic            m_axis_rx_tvalid,
  input  wire             m_axis_rx_tready,
  output rx_keep_t        m_axis_rx_tkeep,
  output logic            m_axis_rx_tlast,
  output rx_tuser_t       m_axis_rx_tuser
);

  // Beat on the bus this cycle
  rx_data_t  cur_data;
  rx_keep_t  cur_keep;
  logic      cur_last;
  logic      cur_valid;
  rx_tuser_t cur_tuser;

  // Beat saved for replay after a stall
  rx_data_t  prev_data;
  rx_keep_t  prev_keep;
  logic      prev_last;
  logic      prev_valid;
  rx_tuser_t prev_tuser;

  // ----------------------------------------------------------
  // Decode, zero latency
  // ----------------------------------------------------------
  rx_beat_decode u_decode (
    .trn_rd        (trn_rd),
    .trn_rsof      (trn_rsof),
    .trn_reof      (trn_reof),
    .trn_rsrc_rdy  (trn_rsrc_rdy),
    .trn_rrem      (trn_rrem),
    .trn_rerrfwd   (trn_rerrfwd),
    .trn_recrc_err (trn_recrc_err),
    .trn_rbar_hit  (trn_rbar_hit),
    .cur_data      (cur_data),
    .cur_keep      (cur_keep),
    .cur_last      (cur_last),
    .cur_valid     (cur_valid),
    .cur_tuser     (cur_tuser)
  );

  // ----------------------------------------------------------
  // Previous value buffer
  // ----------------------------------------------------------
  rx_prev_buffer u_prev (
    .user_clk     (user_clk),
    .user_rst     (user_rst),
    .trn_rdst_rdy (trn_rdst_rdy),  // Load gate
    .cur_data     (cur_data),
    .cur_keep     (cur_keep),
    .cur_last     (cur_last),
    .cur_valid    (cur_valid),
    .cur_tuser    (cur_tuser),
    .prev_data    (prev_data),
    .prev_keep    (prev_keep),
    .prev_last    (prev_last),
    .prev_valid   (prev_valid),
    .prev_tuser   (prev_tuser)
  );

  // ----------------------------------------------------------
  // Output stage, one cycle
  // ----------------------------------------------------------
  rx_output_stage u_out (
    .user_clk         (user_clk),
    .user_rst         (user_rst),
    .cur_data         (cur_data),
    .cur_keep         (cur_keep),
    .cur_last         (cur_last),
    .cur_valid        (cur_valid),
    .cur_tuser        (cur_tuser),
    .prev_data        (prev_data),
    .prev_keep        (prev_keep),
    .prev_last        (prev_last),
    .prev_valid       (prev_valid),
    .prev_tuser       (prev_tuser),
    .m_axis_rx_tready (m_axis_rx_tready),
    .m_axis_rx_tdata  (m_axis_rx_tdata),
    .m_axis_rx_tvalid (m_axis_rx_tvalid),
    .m_axis_rx_tkeep  (m_axis_rx_tkeep),
    .m_axis_rx_tlast  (m_axis_rx_tlast),
    .m_axis_rx_tuser  (m_axis_rx_tuser),
    .trn_rdst_rdy     (trn_rdst_rdy)
  );

endmodule

`default_nettype wire

// File: rx_output_stage.sv
`timescale 1ns/10ps
`default_nettype none

// AXI output registers and back-pressure toward the core
// Three-way buffer
//   HOLD      user stalled, outputs keep their value
//   PREVIOUS  stall just ended, replay the beat caught in the buffer
//   CURRENT   caught up, pass the beat now on the TRN bus
module rx_output_stage
  import trn_rx_pkg::*;
(
  input  wire             user_clk,
  input  wire             user_rst,          // Synchronous, active high

  // Current beat from the decoder
  input  wire rx_data_t   cur_data,
  input  wire rx_keep_t   cur_keep,
  input  wire             cur_last,
  input  wire             cur_valid,
  input  wire rx_tuser_t  cur_tuser,

  // Beat held in the previous buffer
  input  wire rx_data_t   prev_data,
  input  wire rx_keep_t   prev_keep,
  input  wire             prev_last,
  input  wire             prev_valid,
  input  wire rx_tuser_t  prev_tuser,

  // AXI4-Stream master
  input  wire             m_axis_rx_tready,
  output rx_data_t        m_axis_rx_tdata,
  output logic            m_axis_rx_tvalid,
  output rx_keep_t        m_axis_rx_tkeep,
  output logic            m_axis_rx_tlast,
  output rx_tuser_t       m_axis_rx_tuser,

  // Back-pressure to the core
  output logic            trn_rdst_rdy
);

  logic      hold;       // Beat offered and refused
  src_sel_t  src_sel;    // Where the next load comes from
  rx_data_t  sel_data;
  rx_keep_t  sel_keep;
  logic      sel_last;
  logic      sel_valid;
  rx_tuser_t sel_tuser;

  // ----------------------------------------------------------
  // Buffer state
  // ----------------------------------------------------------
  assign hold = m_axis_rx_tvalid && !m_axis_rx_tready;

  // After any stall the core is one beat ahead, so replay first
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      src_sel <= SRC_CURRENT;
    end else begin
      src_sel <= hold ? SRC_PREVIOUS : SRC_CURRENT;
    end
  end

  always_comb begin
    if (src_sel == SRC_PREVIOUS) begin
      sel_data  = prev_data;
      sel_keep  = prev_keep;
      sel_last  = prev_last;
      sel_valid = prev_valid;
      sel_tuser = prev_tuser;
    end else begin
      sel_data  = cur_data;
      sel_keep  = cur_keep;
      sel_last  = cur_last;
      sel_valid = cur_valid;
      sel_tuser = cur_tuser;
    end
  end

  // ----------------------------------------------------------
  // AXI registers
  // ----------------------------------------------------------
  always_ff @(posedge user_clk) begin
    if (!hold) m_axis_rx_tdata <= sel_data;  // Data of the selected beat
  end

  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      m_axis_rx_tvalid <= 1'b0;
      m_axis_rx_tlast  <= 1'b0;
      m_axis_rx_tkeep  <= KEEP_FULL;  // Idle value is all bytes on
      m_axis_rx_tuser  <= '0;
    end else if (!hold) begin
      m_axis_rx_tvalid <= sel_valid;
      m_axis_rx_tlast  <= sel_last;
      m_axis_rx_tkeep  <= sel_keep;
      m_axis_rx_tuser  <= sel_tuser;
    end
  end

  // ----------------------------------------------------------
  // Destination ready
  // ----------------------------------------------------------
  // While a beat is offered, mirror the user's ready one cycle late.
  // With nothing offered, stay open so the first beat of a packet is caught.
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      trn_rdst_rdy <= 1'b0;
    end else if (m_axis_rx_tvalid) begin
      trn_rdst_rdy <= m_axis_rx_tready;
    end else begin
      trn_rdst_rdy <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: rx_prev_buffer.sv
`timescale 1ns/10ps
`default_nettype none

// Previous value buffer
// The output stage adds a cycle between TRN and AXI, so when the user
// throttles, the core has already pushed one more beat than the user took.
// This buffer keeps that beat so it can be replayed once the stall ends.
module rx_prev_buffer
  import trn_rx_pkg::*;
(
  input  wire             user_clk,
  input  wire             user_rst,      // Synchronous, active high
  input  wire             trn_rdst_rdy,  // A new beat is on the bus this cycle

  // Beat from the decoder
  input  wire rx_data_t   cur_data,
  input  wire rx_keep_t   cur_keep,
  input  wire             cur_last,
  input  wire             cur_valid,
  input  wire rx_tuser_t  cur_tuser,

  // Last beat seen while destination ready was high
  output rx_data_t        prev_data,
  output rx_keep_t        prev_keep,
  output logic            prev_last,
  output logic            prev_valid,
  output rx_tuser_t       prev_tuser
);

  // ----------------------------------------------------------
  // Capture
  // ----------------------------------------------------------
  always_ff @(posedge user_clk) begin
    if (user_rst) begin
      prev_data  <= '0;
      prev_keep  <= '0;
      prev_last  <= 1'b0;
      prev_valid <= 1'b0;  // Never replay a beat from before reset
      prev_tuser <= '0;
    end else if (trn_rdst_rdy) begin  // Core only advances while we are ready
      prev_data  <= cur_data;
      prev_keep  <= cur_keep;
      prev_last  <= cur_last;
      prev_valid <= cur_valid;   // Idle slots are kept too, as non-valid
      prev_tuser <= cur_tuser;
    end
    // Otherwise the bus is frozen and the stored beat is still the newest
  end

endmodule

`default_nettype wire

// File: rx_beat_decode.sv
`timescale 1ns/10ps
`default_nettype none

// Turns one raw TRN receive beat into AXI4-Stream fields, no state
module rx_beat_decode
  import trn_rx_pkg::*;
(
  // TRN receive beat
  input  wire rx_data_t   trn_rd,         // Raw TRN data
  input  wire             trn_rsof,       // Start of packet
  input  wire             trn_reof,       // End of packet
  input  wire             trn_rsrc_rdy,   // Core has a beat
  input  wire             trn_rrem,       // 1 = both dwords valid
  input  wire             trn_rerrfwd,    // Error forward
  input  wire             trn_recrc_err,  // ECRC error
  input  wire bar_hit_t   trn_rbar_hit,   // BAR hit

  // Decoded beat
  output rx_data_t        cur_data,       // Dword swapped data
  output rx_keep_t        cur_keep,       // Byte enables
  output logic            cur_last,       // Last beat of packet
  output logic            cur_valid,      // Beat carries data
  output rx_tuser_t       cur_tuser       // Position, BAR and error flags
);

  pos_field_t is_sof;  // Start position field
  pos_field_t is_eof;  // End position field

  // ----------------------------------------------------------
  // Data and byte enables
  // ----------------------------------------------------------
  // TRN dword 0 lands in AXI dword 1 and vice versa
  assign cur_data = {trn_rd[DWORD_W-1:0], trn_rd[DATA_W-1:DWORD_W]};

  assign cur_keep  = trn_rrem ? KEEP_FULL : KEEP_HALF;  // rrem picks one or two dwords
  assign cur_last  = trn_reof;
  assign cur_valid = trn_rsrc_rdy;  // No discontinue filter, source ready passes straight

  // ----------------------------------------------------------
  // Position fields
  // ----------------------------------------------------------
  // Packets are 64-bit aligned, so start is always at byte 0
  assign is_sof = {trn_rsof,  // Enable
                   4'b0000};  // Location, byte 0

  // End sits on byte 3 or byte 7 depending on the remainder
  assign is_eof = {trn_reof,  // Enable
                   1'b0,      // No byte 11 or 15 on a 64-bit bus
                   trn_rrem,  // Upper dword holds the end
                   2'b11};    // Last byte of a dword

  // ----------------------------------------------------------
  // Tuser assembly
  // ----------------------------------------------------------
  always_comb begin
    cur_tuser = '0;  // Reserved bits default low
    cur_tuser[TUSER_EOF_LSB +: POS_W] = is_eof;
    cur_tuser[TUSER_SOF_LSB +: POS_W] = is_sof;
    cur_tuser[TUSER_BAR_LSB +: BAR_W] = trn_rbar_hit;
    cur_tuser[TUSER_ERRFWD_BIT]       = trn_rerrfwd;
    cur_tuser[TUSER_ECRC_BIT]         = trn_recrc_err;
  end

endmodule

`default_nettype wire

// File: trn_rx_pkg.sv
`default_nettype none

package trn_rx_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int DATA_W  = 64;          // TRN and AXI datapath
  localparam int DWORD_W = 32;          // PCIe dword
  localparam int KEEP_W  = DATA_W / 8;  // One enable per byte
  localparam int BAR_W   = 7;           // BAR hit vector
  localparam int POS_W   = 5;           // is_sof / is_eof field
  localparam int TUSER_W = 22;          // AXI user word

  typedef logic [DATA_W-1:0]  rx_data_t;
  typedef logic [KEEP_W-1:0]  rx_keep_t;
  typedef logic [BAR_W-1:0]   bar_hit_t;
  typedef logic [POS_W-1:0]   pos_field_t;  // Bit 4 enable, 3:0 location
  typedef logic [TUSER_W-1:0] rx_tuser_t;

  // ----------------------------------------------------------
  // Tuser layout
  // ----------------------------------------------------------
  // Bits 16:15 and 9 are reserved and always zero
  localparam int TUSER_EOF_LSB    = 17;  // is_eof in 21:17
  localparam int TUSER_SOF_LSB    = 10;  // is_sof in 14:10
  localparam int TUSER_BAR_LSB    = 2;   // BAR hit in 8:2
  localparam int TUSER_ERRFWD_BIT = 1;   // Poisoned TLP
  localparam int TUSER_ECRC_BIT   = 0;   // ECRC error

  // Byte enables on a 64-bit beat, only two shapes are possible
  localparam rx_keep_t KEEP_FULL = 8'hFF;  // Both dwords valid
  localparam rx_keep_t KEEP_HALF = 8'h0F;  // Lower dword only

  // ----------------------------------------------------------
  // Output buffer source
  // ----------------------------------------------------------
  // Registered half of the buffer state, HOLD is decoded on the fly
  typedef enum logic {
    SRC_CURRENT  = 1'b0,  // Pass the beat now on the TRN bus
    SRC_PREVIOUS = 1'b1   // Replay the beat caught during a stall
  } src_sel_t;

endpackage

`default_nettype wire
